// ==== bench/execCases.txt ====
# W addr data | R addr expData expErr | I instr expIllegal expRd expData
# All fields hex; rd and data are ignored on illegal instructions
R 000 00000000 0
W 000 00000001
I 00500093 0 01 00000005
I FFD08113 0 02 00000002
I 00411193 0 03 00000020
I 80000237 0 04 80000000
I 40325293 0 05 F0000000
I 01C2D313 0 06 0000000F
I 003303B3 0 07 0000002F
I 40730433 0 08 FFFFFFE0
I 006424B3 0 09 00000001
I 00643533 0 0A 00000000
I FFF42593 0 0B 00000001
I FFF43613 0 0C 00000001
I 0FF44693 0 0D FFFFFF1F
I 7F06F713 0 0E 00000710
I 00F76793 0 0F 0000071F
I 00979833 0 10 00000E3E
I 410458B3 0 11 FFFFFFFF
I 00E8D933 0 12 0000FFFF
I 011949B3 0 13 FFFF0000
I 0069EA33 0 14 FFFF000F
I 007A7AB3 0 15 0000000F
I 007A8013 0 00 00000016
I 01500B33 0 16 0000000F
I 00112023 1 00 00000000
I 00000063 1 00 00000000
I 00000073 1 00 00000000
I 02208BB3 1 00 00000000
R 008 00000004 0
R 004 00000017 0
R 0A0 FFFFFFE0 0
R 0D8 0000000F 0
R 080 00000000 0
R 0DC 00000000 0
W 004 00000005
R 004 00000017 0
R 010 00000000 1
W 000 00000000
R 000 00000000 0

// ==== files.f ====
design/rvPkg.sv
design/decodeIf.sv
design/decodeStage.sv
design/regFile.sv
design/aluUnit.sv
design/ctrlRegs.sv
design/execCore.sv
bench/execCore_assertions.sv
bench/execCoreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module execCoreTb -f files.f -o execCoreSim
./obj_dir/execCoreSim

// ==== bench/execCoreTb.sv ====
module execCoreTb
    import rvPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    PERIOD       = 20;
    localparam int    RESET_CYCLES = 10;
    localparam int    SEED         = 96869;
    localparam string CASE_FILE    = "bench/execCases.txt";

    logic     clk;
    logic     rst;
    word_t    instr;
    logic     instrValid;
    logic     instrReady;
    apbAddr_t paddr;
    logic     psel;
    logic     penable;
    logic     pwrite;
    word_t    pwdata;
    word_t    prdata;
    logic     pready;
    logic     pslverr;
    logic     wbValid;
    logic     wbIllegal;
    regAddr_t wbRd;
    word_t    wbData;

    logic [16:0] lfsr;
    int          caseLines = 0;

    execCore execCore_i (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .wbValid    (wbValid),
        .wbIllegal  (wbIllegal),
        .wbRd       (wbRd),
        .wbData     (wbData)
    );

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic stopWithFail();
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkWord(input word_t got, input word_t exp, input string what);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stopWithFail();
        end
    endtask

    task automatic checkRegAddr(input regAddr_t got, input regAddr_t exp, input string what);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            stopWithFail();
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stopWithFail();
        end
    endtask

    // Fibonacci LFSR, x^17 + x^14 + 1
    function automatic logic [16:0] stepLfsr(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // Idle gap of 0 to 3 cycles, one LFSR step per bit
    task automatic drawGap(output int gap);
        logic b0;
        logic b1;
        lfsr = stepLfsr(lfsr);
        b0   = lfsr[0];
        lfsr = stepLfsr(lfsr);
        b1   = lfsr[0];
        gap  = {30'b0, b1, b0};
    endtask

    // Zero-wait APB write, only CTRL accepts writes
    task automatic apbWrite(input apbAddr_t addr, input word_t data);
        instrValid = 1'b0;
        paddr      = addr;
        pwrite     = 1'b1;
        pwdata     = data;
        psel       = 1'b1;
        penable    = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        // Mid-cycle sample of the access phase
        #(PERIOD / 4);
        checkFlag(pready, 1'b1, "pready");
        checkFlag(pslverr, addr != ADDR_CTRL, $sformatf("pslverr on write to %h", addr));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        // instrReady mirrors the enable bit
        if (addr == ADDR_CTRL)
            checkFlag(instrReady, data[0], "instrReady after CTRL write");
    endtask

    task automatic apbRead(input apbAddr_t addr, input word_t expData, input logic expErr);
        instrValid = 1'b0;
        paddr      = addr;
        pwrite     = 1'b0;
        psel       = 1'b1;
        penable    = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #(PERIOD / 4);
        checkFlag(pready, 1'b1, "pready");
        checkFlag(pslverr, expErr, $sformatf("pslverr on read of %h", addr));
        // Data only means something without an error
        if (!expErr)
            checkWord(prdata, expData, $sformatf("prdata at %h", addr));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Offer one instruction, check writeback in the cycle after acceptance
    task automatic runInstr(input word_t word, input logic expIll, input regAddr_t expRd,
                            input word_t expData, input int gap);
        if (gap > 0)
        begin
            instrValid = 1'b0;
            repeat (gap) @(negedge clk);
        end
        instr      = word;
        instrValid = 1'b1;
        // Held until the DUT is ready
        while (!instrReady)
            @(negedge clk);
        @(posedge clk);
        @(negedge clk);
        checkFlag(wbIllegal, expIll, $sformatf("wbIllegal for %h", word));
        checkFlag(wbValid, !expIll, $sformatf("wbValid for %h", word));
        if (!expIll)
        begin
            checkRegAddr(wbRd, expRd, $sformatf("wbRd for %h", word));
            checkWord(wbData, expData, $sformatf("wbData for %h", word));
        end
    endtask

    // Watchdog sized from the case count
    initial
    begin
        int limit;
        wait (caseLines > 0);
        limit = (RESET_CYCLES + caseLines * (10 + 3) + 20) * PERIOD;
        #(limit);
        $display("Timeout: the cases did not finish within %0d ns", limit);
        stopWithFail();
    end

    initial
    begin
        int          fd;
        int          n;
        int          ch;
        int          gap;
        int          lines;
        logic [7:0]  kind;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;

        rst        = 1'b1;
        instr      = '0;
        instrValid = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        lfsr       = SEED[16:0];
        lines      = 0;

        // First pass counts lines for the watchdog
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the case file %s", CASE_FILE);
            stopWithFail();
        end
        ch = $fgetc(fd);
        while (ch != -1)
        begin
            if (ch == 10)
                lines++;
            ch = $fgetc(fd);
        end
        $fclose(fd);
        if (lines == 0)
        begin
            $display("The case file %s is empty", CASE_FILE);
            stopWithFail();
        end
        caseLines = lines;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Idle state after reset
        checkFlag(instrReady, 1'b0, "instrReady after reset");
        checkFlag(wbValid, 1'b0, "wbValid after reset");
        checkFlag(wbIllegal, 1'b0, "wbIllegal after reset");
        checkFlag(pslverr, 1'b0, "pslverr after reset");

        fd = $fopen(CASE_FILE, "r");
        while (!$feof(fd))
        begin
            n = $fscanf(fd, " %c", kind);
            if (n != 1)
                break;
            case (kind)
                "#":
                begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1)
                        ch = $fgetc(fd);
                end
                "W":
                begin
                    n = $fscanf(fd, "%h %h", f1, f2);
                    if (n != 2)
                    begin
                        $display("A write line in the case file has missing fields");
                        stopWithFail();
                    end
                    apbWrite(f1[11:0], f2);
                end
                "R":
                begin
                    n = $fscanf(fd, "%h %h %h", f1, f2, f3);
                    if (n != 3)
                    begin
                        $display("A read line in the case file has missing fields");
                        stopWithFail();
                    end
                    apbRead(f1[11:0], f2, f3[0]);
                end
                "I":
                begin
                    n = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                    if (n != 4)
                    begin
                        $display("An instruction line in the case file has missing fields");
                        stopWithFail();
                    end
                    drawGap(gap);
                    runInstr(f1, f2[0], f3[4:0], f4, gap);
                end
                default:
                begin
                    $display("Unknown line kind '%c' in the case file", kind);
                    stopWithFail();
                end
            endcase
        end
        $fclose(fd);

        instrValid = 1'b0;
        @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== bench/execCore_assertions.sv ====
module execCoreChecker
(
    input logic clk,
    input logic rst,
    input logic instrValid,
    input logic instrReady,
    input logic enable,
    input logic wbValid,
    input logic wbIllegal
);

    timeunit 1ns;
    timeprecision 1ps;

    // Back-pressure while disabled, nothing reaches the decode register
    heldWhileDisabled: assert property (@(posedge clk) disable iff (rst)
        !enable |=> !(wbValid || wbIllegal))
        else $error("instruction entered decode with the enable bit clear");

    // One writeback outcome per accepted instruction
    acceptGivesResult: assert property (@(posedge clk) disable iff (rst)
        (instrValid && instrReady) |=> (wbValid ^ wbIllegal))
        else $error("accepted instruction without exactly one writeback flag");

    // No writeback flag without an acceptance the cycle before
    resultNeedsAccept: assert property (@(posedge clk) disable iff (rst)
        (wbValid || wbIllegal) |-> $past(instrValid && instrReady))
        else $error("writeback flag without a preceding acceptance");

    // Empty decode register in reset
    quietInReset: assert property (@(posedge clk) rst |-> !wbValid)
        else $error("wbValid high during reset");

endmodule

bind execCore execCoreChecker execCoreChecker_i (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .instrReady (instrReady),
    .enable     (enable),
    .wbValid    (wbValid),
    .wbIllegal  (wbIllegal)
);

// ==== design/execCore.sv ====
module execCore
    import rvPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    // Instruction handshake
    input  word_t    instr,
    input  logic     instrValid,
    output logic     instrReady,
    // APB slave
    input  apbAddr_t paddr,
    input  logic     psel,
    input  logic     penable,
    input  logic     pwrite,
    input  word_t    pwdata,
    output word_t    prdata,
    output logic     pready,
    output logic     pslverr,
    // Writeback
    output logic     wbValid,
    output logic     wbIllegal,
    output regAddr_t wbRd,
    output word_t    wbData
);

    logic     enable;
    logic     accept;
    word_t    rs1Data;
    word_t    rs2Data;
    word_t    aluResult;
    regAddr_t dbgAddr;
    word_t    dbgData;

    decodeIf decBus ();

    // Back-pressure from the enable bit alone
    assign instrReady = enable;
    assign accept     = instrValid & enable;

    decodeStage decodeStage_i (
        .clk    (clk),
        .rst    (rst),
        .instr  (instr),
        .accept (accept),
        .dec    (decBus.producer)
    );

    regFile regFile_i (
        .clk     (clk),
        .rst     (rst),
        .dec     (decBus.consumer),
        .wrData  (aluResult),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .dbgAddr (dbgAddr),
        .dbgData (dbgData)
    );

    aluUnit aluUnit_i (
        .dec     (decBus.consumer),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .result  (aluResult)
    );

    ctrlRegs ctrlRegs_i (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .enable  (enable),
        .retire  (decBus.regWrite),
        .illegal (decBus.illegal),
        .dbgAddr (dbgAddr),
        .dbgData (dbgData)
    );

    // Writeback shown during the decode cycle
    assign wbValid   = decBus.regWrite;
    assign wbIllegal = decBus.illegal;
    assign wbRd      = decBus.rd;
    assign wbData    = aluResult;

endmodule

// ==== design/ctrlRegs.sv ====
module ctrlRegs
    import rvPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  apbAddr_t paddr,
    input  logic     psel,
    input  logic     penable,
    input  logic     pwrite,
    input  word_t    pwdata,
    output word_t    prdata,
    output logic     pready,
    output logic     pslverr,
    output logic     enable,
    input  logic     retire,
    input  logic     illegal,
    output regAddr_t dbgAddr,
    input  word_t    dbgData
);

    logic  access;
    logic  hitCtrl;
    logic  hitRetired;
    logic  hitIllegal;
    logic  hitWindow;
    logic  mapped;
    logic  errResp;
    logic  enableReg;
    word_t retiredCnt;
    word_t illegalCnt;

    // Access phase of a transfer
    assign access = psel & penable;

    // Address decode
    assign hitCtrl    = (paddr == ADDR_CTRL);
    assign hitRetired = (paddr == ADDR_RETIRED);
    assign hitIllegal = (paddr == ADDR_ILLEGAL);
    // Window 0x080 to 0x0FC, word aligned
    assign hitWindow  = (paddr[11:7] == REG_WINDOW_BASE[11:7]) && (paddr[1:0] == 2'b00);
    assign mapped     = hitCtrl | hitRetired | hitIllegal | hitWindow;

    // Unmapped, or a write to anything but CTRL
    assign errResp = ~mapped | (pwrite & ~hitCtrl);

    assign dbgAddr = paddr[6:2];

    // Enable bit and counters
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            enableReg  <= 1'b0;
            retiredCnt <= '0;
            illegalCnt <= '0;
        end
        else
        begin
            if (access && pwrite && hitCtrl)
                enableReg <= pwdata[0];
            // Both counters wrap
            if (retire)
                retiredCnt <= retiredCnt + 1'b1;
            if (illegal)
                illegalCnt <= illegalCnt + 1'b1;
        end
    end

    // Read mux
    always_comb
    begin
        if (hitCtrl)
            prdata = {31'b0, enableReg};
        else if (hitRetired)
            prdata = retiredCnt;
        else if (hitIllegal)
            prdata = illegalCnt;
        else if (hitWindow)
            prdata = dbgData;
        else
            prdata = '0;
    end

    // No wait states
    assign pready  = 1'b1;
    assign pslverr = access & errResp;
    assign enable  = enableReg;

endmodule

// ==== design/aluUnit.sv ====
module aluUnit
    import rvPkg::*;
(
    decodeIf.consumer dec,
    input  word_t     rs1Data,
    input  word_t     rs2Data,
    output word_t     result
);

    word_t      opA;
    word_t      opB;
    logic [4:0] shAmt;
    word_t      rawResult;

    assign opA = rs1Data;
    // Immediate forms take B from the decoder
    assign opB = dec.useImm ? dec.imm : rs2Data;
    // Shifts use the low five bits only
    assign shAmt = opB[4:0];

    always_comb
    begin
        case (dec.aluOp)
            ALU_ADD:   rawResult = opA + opB;
            ALU_SUB:   rawResult = opA - opB;
            ALU_SLL:   rawResult = opA << shAmt;
            // Signed compare
            ALU_SLT:   rawResult = {31'b0, $signed(opA) < $signed(opB)};
            // Unsigned compare
            ALU_SLTU:  rawResult = {31'b0, opA < opB};
            ALU_XOR:   rawResult = opA ^ opB;
            ALU_SRL:   rawResult = opA >> shAmt;
            // Arithmetic shift keeps the sign
            ALU_SRA:   rawResult = word_t'($signed(opA) >>> shAmt);
            ALU_OR:    rawResult = opA | opB;
            ALU_AND:   rawResult = opA & opB;
            ALU_PASSB: rawResult = opB;
            default:   rawResult = '0;
        endcase
    end

    // Quiet result while the decode register is empty
    assign result = dec.valid ? rawResult : '0;

endmodule

// ==== design/regFile.sv ====
module regFile
    import rvPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    decodeIf.consumer dec,
    input  word_t     wrData,
    output word_t     rs1Data,
    output word_t     rs2Data,
    input  regAddr_t  dbgAddr,
    output word_t     dbgData
);

    word_t regs [32];

    // Writeback at the edge ending the decode cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (dec.regWrite && (dec.rd != '0))
        begin
            // x0 never stored
            regs[dec.rd] <= wrData;
        end
    end

    // Combinational reads, x0 forced to zero
    assign rs1Data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rs2Data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

    // APB window port
    assign dbgData = (dbgAddr == '0) ? '0 : regs[dbgAddr];

endmodule

// ==== design/decodeStage.sv ====
module decodeStage
    import rvPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  word_t     instr,
    input  logic      accept,
    decodeIf.producer dec
);

    word_t      instrReg;
    logic       validReg;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      immI;
    word_t      immU;
    word_t      immShamt;
    word_t      immSel;
    aluOp_t     opSel;
    logic       useImmSel;
    logic       legal;

    // Base operation per func3, before func7 selects SUB or SRA
    function automatic aluOp_t baseOp(input logic [2:0] f3);
        aluOp_t op;
        case (f3)
            F3_ADD_SUB: op = ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    // Valid bit follows acceptance, one instruction per cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            validReg <= 1'b0;
        else
            validReg <= accept;
    end

    // Instruction word only loads on a transfer
    always_ff @(posedge clk)
    begin
        if (accept)
            instrReg <= instr;
    end

    // Field split
    assign opcode = instrReg[6:0];
    assign funct3 = instrReg[14:12];
    assign funct7 = instrReg[31:25];

    // I-type, sign bit copied into the upper 20 bits
    assign immI     = {{20{instrReg[31]}}, instrReg[31:20]};
    // Shift amount only, keeps func7 out of operand B
    assign immShamt = {27'b0, instrReg[24:20]};
    // U-type, low 12 bits zero
    assign immU     = {instrReg[31:12], 12'b0};

    // Control decode
    always_comb
    begin
        opSel     = ALU_ADD;
        immSel    = immI;
        useImmSel = 1'b0;
        legal     = 1'b0;
        case (opcode)
            OPC_LUI:
            begin
                opSel     = ALU_PASSB;
                immSel    = immU;
                useImmSel = 1'b1;
                legal     = 1'b1;
            end
            OPC_OPIMM:
            begin
                opSel     = baseOp(funct3);
                useImmSel = 1'b1;
                legal     = 1'b1;
                if (funct3 == F3_SLL)
                begin
                    immSel = immShamt;
                    legal  = (funct7 == F7_BASE);
                end
                else if (funct3 == F3_SRL_SRA)
                begin
                    immSel = immShamt;
                    // SRAI marked by func7 0x20
                    if (funct7 == F7_ALT)
                        opSel = ALU_SRA;
                    legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                end
            end
            OPC_OP:
            begin
                opSel = baseOp(funct3);
                if (funct7 == F7_BASE)
                    legal = 1'b1;
                else if (funct7 == F7_ALT)
                begin
                    // Only SUB and SRA have an alternate form
                    opSel = (funct3 == F3_ADD_SUB) ? ALU_SUB : ALU_SRA;
                    legal = (funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA);
                end
            end
            default:
            begin
                // Loads, stores, branches, jumps, system: all illegal here
                legal = 1'b0;
            end
        endcase
    end

    // Decoded instruction out
    assign dec.valid    = validReg;
    assign dec.rs1      = instrReg[19:15];
    assign dec.rs2      = instrReg[24:20];
    assign dec.rd       = instrReg[11:7];
    assign dec.imm      = immSel;
    assign dec.useImm   = useImmSel;
    assign dec.aluOp    = opSel;
    assign dec.regWrite = validReg & legal;
    assign dec.illegal  = validReg & ~legal;

endmodule

// ==== design/decodeIf.sv ====
interface decodeIf
    import rvPkg::*;
();

    // Decode register holds an instruction
    logic     valid;
    // Register fields
    regAddr_t rs1;
    regAddr_t rs2;
    regAddr_t rd;
    // Sign-extended immediate, or upper immediate for LUI
    word_t    imm;
    logic     useImm;
    aluOp_t   aluOp;
    // Valid and legal, valid and not legal
    logic     regWrite;
    logic     illegal;

    modport producer (
        output valid, rs1, rs2, rd, imm, useImm, aluOp, regWrite, illegal
    );

    modport consumer (
        input valid, rs1, rs2, rd, imm, useImm, aluOp, regWrite, illegal
    );

endinterface

// ==== design/rvPkg.sv ====
package rvPkg;

    // Data and instruction word
    typedef logic [31:0] word_t;

    // Register index, x0 to x31
    typedef logic [4:0] regAddr_t;

    // ALU operation select
    typedef logic [3:0] aluOp_t;

    // APB byte address
    typedef logic [11:0] apbAddr_t;

    // Executed major opcodes
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_OP    = 7'b0110011;

    // func3 encodings shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // func7 values, base and alternate (SUB, SRA)
    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;

    // ALU operations
    localparam aluOp_t ALU_ADD   = 4'd0;
    localparam aluOp_t ALU_SUB   = 4'd1;
    localparam aluOp_t ALU_SLL   = 4'd2;
    localparam aluOp_t ALU_SLT   = 4'd3;
    localparam aluOp_t ALU_SLTU  = 4'd4;
    localparam aluOp_t ALU_XOR   = 4'd5;
    localparam aluOp_t ALU_SRL   = 4'd6;
    localparam aluOp_t ALU_SRA   = 4'd7;
    localparam aluOp_t ALU_OR    = 4'd8;
    localparam aluOp_t ALU_AND   = 4'd9;
    // Operand B straight through, used by LUI
    localparam aluOp_t ALU_PASSB = 4'd10;

    // APB register map
    localparam apbAddr_t ADDR_CTRL       = 12'h000;
    localparam apbAddr_t ADDR_RETIRED    = 12'h004;
    localparam apbAddr_t ADDR_ILLEGAL    = 12'h008;
    // Register n at base + 4n
    localparam apbAddr_t REG_WINDOW_BASE = 12'h080;

endpackage
